//--- rtl/fifo_params.svh
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// Queue geometry
`define FIFO_DATA_WIDTH 32
`define FIFO_DEPTH_LOG2 5

// APB address bus
`define APB_ADDR_WIDTH 12

// Register map
`define REG_PUSH   12'h000
`define REG_POP    12'h004
`define REG_STATUS 12'h008

`endif

//--- rtl/apb_pkg.sv
`include "fifo_params.svh"

package apb_pkg;

    // Master to slave
    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic                       pwrite;
        logic [`APB_ADDR_WIDTH-1:0] paddr;
        logic [31:0]                pwdata;
    } apb_req_t;

    // Slave to master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_WAIT_CTRL,
        APB_DONE
    } apb_state_e;

endpackage

//--- rtl/fifo_pkg.sv
`include "fifo_params.svh"

package fifo_pkg;

    // OP_BAD covers unmapped addresses and writes to read-only registers
    typedef enum logic [1:0] {
        OP_PUSH,
        OP_POP,
        OP_STATUS,
        OP_BAD
    } fifo_op_e;

    typedef struct packed {
        logic                        valid;
        fifo_op_e                    op;
        logic [`FIFO_DATA_WIDTH-1:0] data;
    } fifo_cmd_t;

    typedef struct packed {
        logic        valid;
        logic        err;
        logic [31:0] data;
    } fifo_rsp_t;

    // Count needs one extra bit to reach the full depth
    typedef struct packed {
        logic [`FIFO_DEPTH_LOG2:0] count;
        logic                      full;
        logic                      empty;
    } fifo_status_t;

    typedef struct packed {
        logic                        en;
        logic [`FIFO_DEPTH_LOG2-1:0] addr;
        logic [`FIFO_DATA_WIDTH-1:0] data;
    } mem_write_t;

endpackage

//--- rtl/memory_mlab.sv
module memory_mlab #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_LOG2 = 5
) (
    input  logic                  clk,
    input  logic                  rstReadAddr,

    input  logic                  write_enable,
    input  logic [DEPTH_LOG2-1:0] write_addr,
    input  logic [WIDTH-1:0]      data_in,

    input  logic                  read_address_stall,
    input  logic [DEPTH_LOG2-1:0] read_addr,
    output logic [WIDTH-1:0]      data_out
);

    logic [WIDTH-1:0]      mem [(1 << DEPTH_LOG2)];

    logic [DEPTH_LOG2-1:0] write_addr_q;
    logic [WIDTH-1:0]      write_data_q;
    logic                  write_enable_q;
    logic [DEPTH_LOG2-1:0] read_addr_q;

    // Write side registered, array updated one edge later
    always_ff @(posedge clk) begin
        if (write_enable_q) begin
            mem[write_addr_q] <= write_data_q;
        end
        write_addr_q   <= write_addr;
        write_data_q   <= data_in;
        write_enable_q <= write_enable;
    end

    // Read address clears asynchronously
    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            read_addr_q <= '0;
        end else if (!read_address_stall) begin
            read_addr_q <= read_addr;
        end
    end

    // Unregistered output
    assign data_out = mem[read_addr_q];

endmodule

//--- rtl/apb_fifo_port.sv
`include "fifo_params.svh"

module apb_fifo_port
    import apb_pkg::*;
    import fifo_pkg::*;
(
    input  logic      clk,
    input  logic      rstReadAddr,
    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,
    output fifo_cmd_t cmd,
    input  fifo_rsp_t rsp
);

    apb_state_e state;

    logic                        setup;
    fifo_op_e                    op_dec;

    logic                        cmd_valid_q;
    fifo_op_e                    cmd_op_q;
    logic [`FIFO_DATA_WIDTH-1:0] cmd_data_q;

    logic                        pready_q;
    logic                        pslverr_q;
    logic [31:0]                 prdata_q;

    assign setup = apb_req.psel && !apb_req.penable;

    // Address and direction to queue opcode
    always_comb begin
        op_dec = OP_BAD;
        case (apb_req.paddr)
            `REG_PUSH: begin
                if (apb_req.pwrite) begin
                    op_dec = OP_PUSH;
                end
            end
            `REG_POP: begin
                if (!apb_req.pwrite) begin
                    op_dec = OP_POP;
                end
            end
            `REG_STATUS: begin
                if (!apb_req.pwrite) begin
                    op_dec = OP_STATUS;
                end
            end
            default: op_dec = OP_BAD;
        endcase
    end

    // Command registered in the setup cycle, so valid sits on the first access cycle
    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            state       <= APB_IDLE;
            cmd_valid_q <= 1'b0;
            pready_q    <= 1'b0;
            pslverr_q   <= 1'b0;
        end else begin
            cmd_valid_q <= 1'b0;
            pready_q    <= 1'b0;
            pslverr_q   <= 1'b0;
            case (state)
                APB_IDLE: begin
                    if (setup) begin
                        cmd_valid_q <= 1'b1;
                        state       <= APB_WAIT_CTRL;
                    end
                end
                APB_WAIT_CTRL: begin
                    if (rsp.valid) begin
                        pready_q  <= 1'b1;
                        pslverr_q <= rsp.err;
                        state     <= APB_DONE;
                    end
                end
                APB_DONE: state <= APB_IDLE;
                default:  state <= APB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == APB_IDLE && setup) begin
            cmd_op_q   <= op_dec;
            cmd_data_q <= apb_req.pwdata;
        end
        if (state == APB_WAIT_CTRL && rsp.valid) begin
            prdata_q <= rsp.data;
        end
    end

    assign cmd     = '{valid: cmd_valid_q, op: cmd_op_q, data: cmd_data_q};
    assign apb_rsp = '{prdata: prdata_q, pready: pready_q, pslverr: pslverr_q};

endmodule

//--- rtl/fifo_queue_ctrl.sv
`include "fifo_params.svh"

module fifo_queue_ctrl
    import fifo_pkg::*;
(
    input  logic                        clk,
    input  logic                        rstReadAddr,
    input  fifo_cmd_t                   cmd,
    output fifo_rsp_t                   rsp,
    output mem_write_t                  mem_wr,
    output logic [`FIFO_DEPTH_LOG2-1:0] rd_addr,
    output logic                        rd_stall,
    input  logic [`FIFO_DATA_WIDTH-1:0] rd_data
);

    localparam logic [`FIFO_DEPTH_LOG2:0] ENTRIES =
        (`FIFO_DEPTH_LOG2 + 1)'(1 << `FIFO_DEPTH_LOG2);

    logic [`FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [`FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [`FIFO_DEPTH_LOG2:0]   count;
    fifo_status_t                status;
    logic [31:0]                 status_word;

    logic                        push_ok;
    logic                        pop_go;
    logic                        cmd_err;
    logic                        pop_pending;

    logic                        rsp_valid;
    logic                        rsp_err;
    logic [31:0]                 rsp_data;

    logic                        wr_en_q;
    logic [`FIFO_DEPTH_LOG2-1:0] wr_addr_q;
    logic [`FIFO_DATA_WIDTH-1:0] wr_data_q;

    assign status.count = count;
    assign status.full  = (count == ENTRIES);
    assign status.empty = (count == '0);

    // Status register layout
    always_comb begin
        status_word                     = '0;
        status_word[`FIFO_DEPTH_LOG2:0] = status.count;
        status_word[8]                  = status.full;
        status_word[9]                  = status.empty;
    end

    assign push_ok = cmd.valid && cmd.op == OP_PUSH && !status.full;
    assign pop_go  = cmd.valid && cmd.op == OP_POP && !status.empty;
    assign cmd_err = cmd.valid && !push_ok && !pop_go && cmd.op != OP_STATUS;

    // Head address is taken only in the pop command cycle
    assign rd_addr  = rd_ptr;
    assign rd_stall = !pop_go;

    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            pop_pending <= 1'b0;
            rsp_valid   <= 1'b0;
            rsp_err     <= 1'b0;
            wr_en_q     <= 1'b0;
        end else begin
            pop_pending <= pop_go;
            wr_en_q     <= push_ok;
            // A good pop answers one cycle later, once the data is out
            rsp_valid   <= (cmd.valid && !pop_go) || pop_pending;
            rsp_err     <= cmd_err;
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
                count  <= count + 1'b1;
            end
            if (pop_pending) begin
                rd_ptr <= rd_ptr + 1'b1;
                count  <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_pending) begin
            rsp_data <= rd_data;
        end else if (cmd.valid) begin
            rsp_data <= (cmd.op == OP_STATUS) ? status_word : '0;
        end
        if (push_ok) begin
            wr_addr_q <= wr_ptr;
            wr_data_q <= cmd.data;
        end
    end

    assign rsp    = '{valid: rsp_valid, err: rsp_err, data: rsp_data};
    assign mem_wr = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

endmodule

//--- rtl/apb_fifo_top.sv
`include "fifo_params.svh"

module apb_fifo_top
    import apb_pkg::*;
    import fifo_pkg::*;
(
    input  logic     clk,
    input  logic     rstReadAddr,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    fifo_cmd_t                   cmd;
    fifo_rsp_t                   rsp;
    mem_write_t                  mem_wr;
    logic [`FIFO_DEPTH_LOG2-1:0] rd_addr;
    logic                        rd_stall;
    logic [`FIFO_DATA_WIDTH-1:0] rd_data;

    apb_fifo_port apb_fifo_port_i (
        .clk         (clk),
        .rstReadAddr (rstReadAddr),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .cmd         (cmd),
        .rsp         (rsp)
    );

    fifo_queue_ctrl fifo_queue_ctrl_i (
        .clk         (clk),
        .rstReadAddr (rstReadAddr),
        .cmd         (cmd),
        .rsp         (rsp),
        .mem_wr      (mem_wr),
        .rd_addr     (rd_addr),
        .rd_stall    (rd_stall),
        .rd_data     (rd_data)
    );

    memory_mlab #(
        .WIDTH      (`FIFO_DATA_WIDTH),
        .DEPTH_LOG2 (`FIFO_DEPTH_LOG2)
    ) memory_mlab_i (
        .clk                (clk),
        .rstReadAddr        (rstReadAddr),
        .write_enable       (mem_wr.en),
        .write_addr         (mem_wr.addr),
        .data_in            (mem_wr.data),
        .read_address_stall (rd_stall),
        .read_addr          (rd_addr),
        .data_out           (rd_data)
    );

endmodule

//--- verif/apb_fifo_tb.sv
`include "fifo_params.svh"

module apb_fifo_tb
    import apb_pkg::*;
    import fifo_pkg::*;
();

    localparam int DEPTH    = 1 << `FIFO_DEPTH_LOG2;
    localparam int N_WORDS  = 24;
    localparam int N_RANDOM = 400;
    localparam int N_XFERS  = 1 + (2 * N_WORDS + 1) + (2 * (DEPTH + 1) + 2) + 7 + (N_RANDOM + 1);
    localparam longint WATCHDOG_TIME = (longint'(N_XFERS) * 10 + 200) * 10;

    // Status fields inside the read word
    localparam logic [31:0] STATUS_FIELDS = 32'h0000_033F;

    typedef struct packed {
        logic                       write;
        logic [`APB_ADDR_WIDTH-1:0] addr;
        logic [31:0]                wdata;
        logic [31:0]                rdata;
        logic                       slverr;
    } transfer_t;

    logic     clk = 1'b0;
    logic     rstReadAddr;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    transfer_t   done_q[$];
    logic [31:0] model_q[$];
    logic [31:0] lcg_state = 32'd55;
    int          rsp_errors    = 0;
    int          status_errors = 0;
    int          other_errors  = 0;
    int          ready_pulses  = 0;

    apb_fifo_top apb_fifo_top_i (
        .clk         (clk),
        .rstReadAddr (rstReadAddr),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Register map as seen by the host
    function automatic fifo_op_e decode_op(input logic write,
                                           input logic [`APB_ADDR_WIDTH-1:0] addr);
        if (write && addr == `REG_PUSH) begin
            return OP_PUSH;
        end else if (!write && addr == `REG_POP) begin
            return OP_POP;
        end else if (!write && addr == `REG_STATUS) begin
            return OP_STATUS;
        end
        return OP_BAD;
    endfunction

    // For status reads only the bits outside the fields are predicted here
    function automatic fifo_rsp_t ref_rsp(input fifo_op_e op);
        fifo_rsp_t r;
        r.valid = 1'b1;
        r.err   = 1'b0;
        r.data  = '0;
        case (op)
            OP_PUSH:   r.err = (model_q.size() >= DEPTH);
            OP_POP: begin
                if (model_q.size() == 0) begin
                    r.err = 1'b1;
                end else begin
                    r.data = model_q[0];
                end
            end
            OP_STATUS: r.err = 1'b0;
            default:   r.err = 1'b1;
        endcase
        return r;
    endfunction

    function automatic fifo_status_t ref_status();
        fifo_status_t s;
        s.count = (`FIFO_DEPTH_LOG2 + 1)'(model_q.size());
        s.full  = (model_q.size() == DEPTH);
        s.empty = (model_q.size() == 0);
        return s;
    endfunction

    task automatic compare_rsp(input fifo_rsp_t got, input fifo_rsp_t exp, input string what);
        if (got.err !== exp.err || got.data !== exp.data) begin
            rsp_errors++;
            $display("ERR %0t: %s got err %0b data %h, expected err %0b data %h",
                     $time, what, got.err, got.data, exp.err, exp.data);
        end
    endtask

    task automatic compare_status(input fifo_status_t got, input fifo_status_t exp);
        if (got !== exp) begin
            status_errors++;
            $display("ERR %0t: status got count %0d full %0b empty %0b, expected %0d %0b %0b",
                     $time, got.count, got.full, got.empty, exp.count, exp.full, exp.empty);
        end
    endtask

    task automatic check_transfer(input transfer_t rec);
        fifo_op_e     op;
        fifo_rsp_t    got;
        fifo_status_t got_st;
        op        = decode_op(rec.write, rec.addr);
        got.valid = 1'b1;
        got.err   = rec.slverr;
        got.data  = rec.rdata;
        if (op == OP_STATUS) begin
            got_st.count = rec.rdata[`FIFO_DEPTH_LOG2:0];
            got_st.full  = rec.rdata[8];
            got_st.empty = rec.rdata[9];
            got.data     = rec.rdata & ~STATUS_FIELDS;
            compare_status(got_st, ref_status());
        end
        compare_rsp(got, ref_rsp(op), op.name());
        // Model follows the accepted operations only
        if (op == OP_PUSH && model_q.size() < DEPTH) begin
            model_q.push_back(rec.wdata);
        end else if (op == OP_POP && model_q.size() > 0) begin
            void'(model_q.pop_front());
        end
    endtask

    always @(negedge clk) begin
        if (apb_rsp.pready === 1'b1) begin
            ready_pulses++;
        end
        while (done_q.size() > 0) begin
            check_transfer(done_q.pop_front());
        end
    end

    task automatic apb_transfer(input logic write, input logic [`APB_ADDR_WIDTH-1:0] addr,
                                input logic [31:0] wdata);
        apb_req_t  req;
        transfer_t rec;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        req.pwrite  = write;
        req.paddr   = addr;
        req.pwdata  = wdata;
        @(posedge clk);
        apb_req <= req;
        req.penable = 1'b1;
        @(posedge clk);
        apb_req <= req;
        do begin
            @(negedge clk);
        end while (!apb_rsp.pready);
        rec.write  = write;
        rec.addr   = addr;
        rec.wdata  = wdata;
        rec.rdata  = apb_rsp.prdata;
        rec.slverr = apb_rsp.pslverr;
        done_q.push_back(rec);
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_write(input logic [`APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        apb_transfer(1'b1, addr, data);
    endtask

    task automatic apb_read(input logic [`APB_ADDR_WIDTH-1:0] addr);
        apb_transfer(1'b0, addr, 32'h0);
    endtask

    task automatic push_pop_in_order();
        repeat (N_WORDS) apb_write(`REG_PUSH, lcg_next());
        apb_read(`REG_STATUS);
        repeat (N_WORDS) apb_read(`REG_POP);
    endtask

    // One push past full, then drain one past empty
    task automatic fill_and_overflow();
        for (int i = 0; i <= DEPTH; i++) begin
            apb_write(`REG_PUSH, 32'hA500_0000 | i);
        end
        apb_read(`REG_STATUS);
        repeat (DEPTH + 1) apb_read(`REG_POP);
        apb_read(`REG_STATUS);
    endtask

    task automatic error_accesses();
        apb_read(`REG_POP);
        apb_write(`REG_STATUS, 32'hDEAD_BEEF);
        apb_write(`REG_POP, 32'h1234_5678);
        apb_read(`REG_PUSH);
        apb_read(12'h00C);
        apb_write(12'h100, 32'h0BAD_0BAD);
        apb_read(`REG_STATUS);
    endtask

    task automatic random_mix();
        logic [31:0] pick;
        for (int i = 0; i < N_RANDOM; i++) begin
            pick = (lcg_next() >> 16) % 10;
            if (pick < 5) begin
                apb_write(`REG_PUSH, lcg_next());
            end else if (pick < 8) begin
                apb_read(`REG_POP);
            end else if (pick < 9) begin
                apb_read(`REG_STATUS);
            end else begin
                apb_write(`REG_STATUS, lcg_next());
            end
            repeat ((lcg_next() >> 16) % 3) @(posedge clk);
        end
        apb_read(`REG_STATUS);
    endtask

    initial begin
        apb_req     = '0;
        rstReadAddr = 1'b1;
        repeat (16) @(posedge clk);
        rstReadAddr <= 1'b0;

        apb_read(`REG_STATUS);
        push_pop_in_order();
        fill_and_overflow();
        error_accesses();
        random_mix();

        @(negedge clk);
        while (done_q.size() > 0) begin
            @(negedge clk);
        end
        // One pready cycle per transfer
        if (ready_pulses != N_XFERS) begin
            other_errors++;
            $display("The DUT raised pready %0d times for %0d transfers",
                     ready_pulses, N_XFERS);
        end
        $display("Errors: response %0d, status %0d, other %0d",
                 rsp_errors, status_errors, other_errors);
        if (rsp_errors + status_errors + other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
        $display("Errors: response %0d, status %0d, other %0d",
                 rsp_errors, status_errors, other_errors + 1);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- apb_fifo.f
+incdir+rtl
rtl/apb_pkg.sv
rtl/fifo_pkg.sv
rtl/memory_mlab.sv
rtl/apb_fifo_port.sv
rtl/fifo_queue_ctrl.sv
rtl/apb_fifo_top.sv
verif/apb_fifo_tb.sv

//--- Bender.yml
package:
  name: apb_fifo

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/apb_pkg.sv
      - rtl/fifo_pkg.sv
      - rtl/memory_mlab.sv
      - rtl/apb_fifo_port.sv
      - rtl/fifo_queue_ctrl.sv
      - rtl/apb_fifo_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/apb_fifo_tb.sv
